//--- wrSortPkg.sv
/*
 * Write-response sorting shim, shared definitions
 * Widths, header layouts and response kinds used by the tagger,
 * the scoreboard, the sorter and the top level
 */
`default_nettype none

package wrSortPkg;

    // Metadata occupies the low word of every request and response header
    localparam int mdataWidth = 16;
    localparam int txHdrWidth = 48;
    localparam int rxHdrWidth = 20;

    // Default ring depth for the write scoreboard
    localparam int nEntriesDefault = 16;

    typedef logic [mdataWidth-1:0] tMdata;

    // Request header: line address above, user metadata below
    typedef struct packed {
        logic [txHdrWidth-mdataWidth-1:0] addr;
        tMdata                            mdata;
    } tTxHdr;

    // Response kind sits in the bits above the metadata
    typedef enum logic [rxHdrWidth-mdataWidth-1:0] {
        rspWrLine = 4'h1,
        rspFence  = 4'h4
    } tRspKind;

    typedef struct packed {
        tRspKind kind;
        tMdata   mdata;
    } tRxHdr;

endpackage

`default_nettype wire

//--- wrScoreboard.sv
/*
 * Write scoreboard
 * A ring of slots that is allocated strictly in order at the tail,
 * completed in any order by slot index, and released in order from
 * the head. Each slot holds a done bit and a metadata payload whose
 * type is chosen by the instantiating block.
 */
`timescale 1ns/1ns
`default_nettype none

module wrScoreboard
#(
    parameter int  nEntries = wrSortPkg::nEntriesDefault,
    parameter type tMeta    = wrSortPkg::tMdata
)
(
    input  logic                            clk,
    input  logic                            arstN,

    // Allocation port, driven by the request tagger
    input  logic                            allocEn,
    input  tMeta                            allocMeta,
    output logic [$clog2(nEntries)-1:0]     allocIdx,
    output logic [$clog2(nEntries+1)-1:0]   freeCount,

    // Completion port, driven by memory write responses
    input  logic                            doneEn,
    input  logic [$clog2(nEntries)-1:0]     doneIdx,

    // Head of the ring, consumed by the response sorter
    output logic                            headDone,
    output tMeta                            headMeta,
    input  logic                            headPop
);

    localparam int idxWidth = $clog2(nEntries);
    localparam int cntWidth = $clog2(nEntries+1);

    // ========================================
    // Ring state
    // ========================================

    // Oldest outstanding slot
    logic [idxWidth-1:0] headPtr;

    // Next slot to hand out
    logic [idxWidth-1:0] tailPtr;

    // Number of slots not yet allocated
    logic [cntWidth-1:0] freeCnt;

    // One done flag per slot, set by a completion and cleared on release
    logic [nEntries-1:0] doneBits;

    // Saved user metadata, indexed by slot
    tMeta metaMem [nEntries];

    // The tail pointer is the index offered to the next write
    assign allocIdx  = tailPtr;
    assign freeCount = freeCnt;

    // Both head outputs come straight from registers
    assign headDone = doneBits[headPtr];
    assign headMeta = metaMem[headPtr];

    // ========================================
    // Pointers and free count
    // ========================================

    // The ring depth is a power of two, so the pointers wrap on overflow
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            headPtr <= '0;
            tailPtr <= '0;
        end
        else
        begin
            if (allocEn)
            begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (headPop)
            begin
                headPtr <= headPtr + 1'b1;
            end
        end
    end

    // An allocation and a release in the same cycle leave the count as is
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            freeCnt <= cntWidth'(nEntries);
        end
        else
        begin
            case ({allocEn, headPop})
                2'b10:   freeCnt <= freeCnt - 1'b1;
                2'b01:   freeCnt <= freeCnt + 1'b1;
                default: freeCnt <= freeCnt;
            endcase
        end
    end

    // ========================================
    // Done flags and metadata store
    // ========================================

    // Release clears the head flag before a completion is applied
    // A legal completion never targets the slot being released
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            doneBits <= '0;
        end
        else
        begin
            if (headPop)
            begin
                doneBits[headPtr] <= 1'b0;
            end
            if (doneEn)
            begin
                doneBits[doneIdx] <= 1'b1;
            end
        end
    end

    // Metadata is captured at the tail when a slot is taken
    always_ff @(posedge clk)
    begin
        if (allocEn)
        begin
            metaMem[tailPtr] <= allocMeta;
        end
    end

endmodule

`default_nettype wire

//--- wrReqTagger.sv
/*
 * Write request tagger
 * Swaps the user metadata of each write for its scoreboard slot
 * index and forwards requests to memory in the same cycle. Builds
 * the user almost-full flag from the memory flag and the slot count.
 */
`timescale 1ns/1ns
`default_nettype none

module wrReqTagger
#(
    parameter int nEntries     = wrSortPkg::nEntriesDefault,
    parameter int minFreeSlots = 2
)
(
    input  logic                            clk,
    input  logic                            arstN,

    input  logic                            reqWrValid,
    input  logic                            reqFenceValid,
    input  wrSortPkg::tTxHdr                reqHdr,
    output logic                            reqAlmFull,

    output logic                            memWrValid,
    output logic                            memFenceValid,
    output wrSortPkg::tTxHdr                memHdr,
    input  logic                            memAlmFull,

    input  logic [$clog2(nEntries)-1:0]     allocIdx,
    input  logic [$clog2(nEntries+1)-1:0]   freeCount,
    output wrSortPkg::tMdata                allocMeta
);

    import wrSortPkg::*;

    // Registered slot-pressure part of the almost-full flag
    logic slotAlmFull;
    logic nearFull;

    // Requests pass through with no added latency
    assign memWrValid    = reqWrValid;
    assign memFenceValid = reqFenceValid;

    // The original metadata is parked in the scoreboard slot
    assign allocMeta = reqHdr.mdata;

    // Writes carry the slot index, fences keep their header untouched
    always_comb
    begin
        memHdr = reqHdr;
        if (reqWrValid)
        begin
            memHdr.mdata = tMdata'(allocIdx);
        end
    end

    // Look one allocation ahead so the flag rises on the same edge the
    // free count reaches the reserve, and pops are ignored to stay safe
    assign nearFull = int'(freeCount) <= minFreeSlots + int'(reqWrValid);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            slotAlmFull <= 1'b0;
        end
        else
        begin
            slotAlmFull <= nearFull;
        end
    end

    // Memory back-pressure passes straight through
    assign reqAlmFull = memAlmFull || slotAlmFull;

endmodule

`default_nettype wire

//--- wrRspSorter.sv
/*
 * Response sorter
 * Merges fence responses from memory with in-order write responses
 * released from the scoreboard head into one registered stream.
 * Fences win, since only the write path is buffered.
 */
`timescale 1ns/1ns
`default_nettype none

module wrRspSorter
#(
    parameter int nEntries = wrSortPkg::nEntriesDefault
)
(
    input  logic                clk,
    input  logic                arstN,

    // Pass-through responses from memory
    input  logic                memRspFenceValid,
    input  wrSortPkg::tRxHdr    memRspHdr,

    // Scoreboard head
    input  logic                headDone,
    input  wrSortPkg::tMdata    headMeta,
    output logic                headPop,

    // Response stream toward the user
    output logic                rspValid,
    output wrSortPkg::tRxHdr    rspHdr
);

    import wrSortPkg::*;

    // ========================================
    // Ring depth check
    // ========================================

    // The scoreboard pointers wrap by binary overflow, so the depth that
    // all three blocks share has to be a power of two
    if ((nEntries < 2) || ((nEntries & (nEntries - 1)) != 0))
    begin : gDepthCheck
        $error("wrRspSorter: nEntries must be a power of two");
    end

    // ========================================
    // Merge stage
    // ========================================

    // A done head is released only when no fence response claims the stage
    assign headPop = headDone && !memRspFenceValid;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rspValid <= 1'b0;
        end
        else
        begin
            rspValid <= memRspFenceValid || headPop;
        end
    end

    // Header payload; only meaningful when rspValid is high
    always_ff @(posedge clk)
    begin
        if (memRspFenceValid)
        begin
            rspHdr <= memRspHdr;
        end
        else
        begin
            rspHdr.kind  <= rspWrLine;
            rspHdr.mdata <= headMeta;
        end
    end

endmodule

`default_nettype wire

//--- wrSortShim.sv
/*
 * Write-response ordering shim, top level
 * Tags writes with scoreboard slots on the way to memory and returns
 * write responses to the user in issue order with their metadata
 */
`timescale 1ns/1ns
`default_nettype none

module wrSortShim
#(
    parameter int nEntries     = wrSortPkg::nEntriesDefault,
    parameter int minFreeSlots = 2
)
(
    input  logic                clk,
    input  logic                arstN,

    // User side
    input  logic                reqWrValid,
    input  logic                reqFenceValid,
    input  wrSortPkg::tTxHdr    reqHdr,
    output logic                reqAlmFull,
    output logic                rspValid,
    output wrSortPkg::tRxHdr    rspHdr,

    // Memory side
    output logic                memWrValid,
    output logic                memFenceValid,
    output wrSortPkg::tTxHdr    memHdr,
    input  logic                memAlmFull,
    input  logic                memRspWrValid,
    input  logic                memRspFenceValid,
    input  wrSortPkg::tRxHdr    memRspHdr
);

    import wrSortPkg::*;

    localparam int idxWidth = $clog2(nEntries);
    localparam int cntWidth = $clog2(nEntries+1);

    logic [idxWidth-1:0] allocIdx;
    logic [cntWidth-1:0] freeCount;
    tMdata               allocMeta;
    logic [idxWidth-1:0] doneIdx;
    logic                headDone;
    tMdata               headMeta;
    logic                headPop;

    // Memory echoes the slot index in the low metadata bits
    assign doneIdx = memRspHdr.mdata[idxWidth-1:0];

    wrReqTagger #(.nEntries(nEntries), .minFreeSlots(minFreeSlots)) i_tagger (
        .clk, .arstN, .reqWrValid, .reqFenceValid, .reqHdr, .reqAlmFull,
        .memWrValid, .memFenceValid, .memHdr, .memAlmFull,
        .allocIdx, .freeCount, .allocMeta
    );

    // Every write sent to memory takes the slot at the tail
    wrScoreboard #(.nEntries(nEntries), .tMeta(tMdata)) i_scoreboard (
        .clk, .arstN, .allocEn(memWrValid), .allocMeta, .allocIdx, .freeCount,
        .doneEn(memRspWrValid), .doneIdx, .headDone, .headMeta, .headPop
    );

    wrRspSorter #(.nEntries(nEntries)) i_sorter (
        .clk, .arstN, .memRspFenceValid, .memRspHdr,
        .headDone, .headMeta, .headPop, .rspValid, .rspHdr
    );

endmodule

`default_nettype wire

//--- tbWrMemModel.sv
/*
 * Testbench memory model
 * Takes tagged writes and fences from the shim, answers a fence on
 * the next cycle and completes outstanding writes one per cycle in
 * an order picked by the random value from the testbench top
 */
`timescale 1ns/1ns
`default_nettype none

module tbWrMemModel
(
    input  logic                clk,
    input  logic                arstN,
    input  logic                memWrValid,
    input  logic                memFenceValid,
    input  wrSortPkg::tTxHdr    memHdr,
    input  logic                completeEn,
    input  logic [3:0]          pick,
    output logic                memRspWrValid,
    output logic                memRspFenceValid,
    output wrSortPkg::tRxHdr    memRspHdr
);

    import wrSortPkg::*;

    // Slot indices of writes that memory has not answered yet
    tMdata pendQ[$];
    int    sel;

    always @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            memRspWrValid    <= 1'b0;
            memRspFenceValid <= 1'b0;
            pendQ.delete();
        end
        else
        begin
            memRspWrValid    <= 1'b0;
            memRspFenceValid <= 1'b0;
            // Both kinds share one header bus, so a fence holds back completions
            if (memFenceValid)
            begin
                memRspFenceValid <= 1'b1;
                memRspHdr.kind   <= rspFence;
                memRspHdr.mdata  <= memHdr.mdata;
            end
            else if (completeEn && pendQ.size() > 0)
            begin
                // Any outstanding write may finish, not only the oldest
                sel = int'(pick) % pendQ.size();
                memRspWrValid   <= 1'b1;
                memRspHdr.kind  <= rspWrLine;
                memRspHdr.mdata <= pendQ[sel];
                pendQ.delete(sel);
            end
            // A write taken on this edge can only complete on a later one
            if (memWrValid)
            begin
                pendQ.push_back(memHdr.mdata);
            end
        end
    end

endmodule

`default_nettype wire

//--- tbWrSort.sv
/*
 * Testbench for the write-response ordering shim
 * Drives random writes and fences through the shim into a memory
 * model that completes writes out of order, and checks that the
 * user sees responses in issue order with their own metadata, that
 * fences bypass on time and that almost-full behaves around the reserve
 */
`timescale 1ns/1ns
`default_nettype none

module tbWrSort;

    import wrSortPkg::*;

    localparam int nEntries     = 16;
    localparam int minFreeSlots = 2;
    localparam int idxWidth     = $clog2(nEntries);
    localparam int nRandReqs    = 200;

    logic        clk;
    logic        arstN;
    logic        reqWrValid;
    logic        reqFenceValid;
    tTxHdr       reqHdr;
    logic        reqAlmFull;
    logic        rspValid;
    tRxHdr       rspHdr;
    logic        memWrValid;
    logic        memFenceValid;
    tTxHdr       memHdr;
    logic        memAlmFull;
    logic        memRspWrValid;
    logic        memRspFenceValid;
    tRxHdr       memRspHdr;
    logic        completeEn;
    logic [3:0]  pick;

    // Expected responses in order, and the cycle each fence is due
    tMdata               wrQ[$];
    tMdata               fenceQ[$];
    int                  fenceDueQ[$];
    logic [nEntries-1:0] slotBusy;
    int                  wrIssued;
    int                  cycleCnt;
    int                  valueErrs;
    int                  flagErrs;
    int                  protoErrs;
    int                  timeouts;
    logic [15:0]         lfsrState;

    wrSortShim #(.nEntries(nEntries), .minFreeSlots(minFreeSlots)) i_dut (
        .clk, .arstN, .reqWrValid, .reqFenceValid, .reqHdr, .reqAlmFull,
        .rspValid, .rspHdr, .memWrValid, .memFenceValid, .memHdr, .memAlmFull,
        .memRspWrValid, .memRspFenceValid, .memRspHdr
    );

    tbWrMemModel i_mem (
        .clk, .arstN, .memWrValid, .memFenceValid, .memHdr, .completeEn, .pick,
        .memRspWrValid, .memRspFenceValid, .memRspHdr
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================
    // Random source and reference
    // ========================================

    // Taps of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit handed out
    task automatic randBits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            val = {val[14:0], lfsrState[0]};
        end
    endtask

    // A user response is the kind in the top bits over the request metadata
    function automatic tRxHdr expectedRsp(input tRspKind kindVal, input tMdata mdVal);
        tRxHdr h;
        h.kind  = kindVal;
        h.mdata = mdVal;
        return h;
    endfunction

    task automatic compareHdr(input string name, input tRxHdr got, input tRxHdr exp);
        if (got !== exp)
        begin
            valueErrs++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareKind(input string name, input tRspKind got, input tRspKind exp);
        if (got !== exp)
        begin
            valueErrs++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareTxHdr(input string name, input tTxHdr got, input tTxHdr exp);
        if (got !== exp)
        begin
            valueErrs++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic compareFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            flagErrs++;
            $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic noteProblem(input string msg);
        protoErrs++;
        $display("%s at %0t", msg, $time);
    endtask

    // ========================================
    // Response checker
    // ========================================

    // Sampled on the falling edge, where every registered output is settled
    always @(negedge clk)
    begin
        tMdata md;
        tTxHdr txExp;
        int    due;
        if (arstN)
        begin
            cycleCnt++;
            if (rspValid && rspHdr.kind == rspFence)
            begin
                if (fenceQ.size() == 0)
                begin
                    noteProblem("Fence response arrived with no fence outstanding");
                end
                else
                begin
                    md  = fenceQ.pop_front();
                    due = fenceDueQ.pop_front();
                    if (cycleCnt != due)
                    begin
                        noteProblem($sformatf("Fence response came in cycle %0d, due in %0d",
                                              cycleCnt, due));
                    end
                    compareHdr("rspHdr", rspHdr, expectedRsp(rspFence, md));
                end
            end
            else if (rspValid)
            begin
                compareKind("rspHdr.kind", rspHdr.kind, rspWrLine);
                if (wrQ.size() == 0)
                begin
                    noteProblem("Write response arrived with no write outstanding");
                end
                else
                begin
                    md = wrQ.pop_front();
                    compareHdr("rspHdr", rspHdr, expectedRsp(rspWrLine, md));
                end
            end
            if (memRspWrValid)
            begin
                slotBusy[memRspHdr.mdata[idxWidth-1:0]] = 1'b0;
            end
            // Requests reach memory in the same cycle as they are driven
            compareFlag("memWrValid", memWrValid, reqWrValid);
            compareFlag("memFenceValid", memFenceValid, reqFenceValid);
            // Slots go out in ring order and never twice while outstanding
            if (reqWrValid)
            begin
                txExp.addr  = reqHdr.addr;
                txExp.mdata = tMdata'(wrIssued % nEntries);
                compareTxHdr("memHdr", memHdr, txExp);
                if (slotBusy[memHdr.mdata[idxWidth-1:0]])
                begin
                    noteProblem("Slot index sent to memory while that slot is outstanding");
                end
                slotBusy[memHdr.mdata[idxWidth-1:0]] = 1'b1;
                wrQ.push_back(reqHdr.mdata);
                wrIssued++;
            end
            // Fences reach memory with the user header untouched
            if (reqFenceValid)
            begin
                compareTxHdr("memHdr", memHdr, reqHdr);
                fenceQ.push_back(reqHdr.mdata);
                fenceDueQ.push_back(cycleCnt + 2);
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================

    // Next drive point, with the request strobes dropped and a new memory pick
    task automatic tick();
        logic [15:0] r;
        @(posedge clk);
        #5;
        reqWrValid    = 1'b0;
        reqFenceValid = 1'b0;
        randBits(4, r);
        pick = r[3:0];
    endtask

    task automatic sendWrite();
        logic [15:0] md;
        randBits(16, md);
        reqWrValid   = 1'b1;
        reqHdr.addr  = {10'h200, md, 6'h0};
        reqHdr.mdata = md;
    endtask

    task automatic sendFence();
        logic [15:0] md;
        randBits(16, md);
        reqFenceValid = 1'b1;
        reqHdr.addr   = '0;
        reqHdr.mdata  = md;
    endtask

    task automatic waitDrain(input int maxCycles, input string what);
        int n;
        n = 0;
        while ((wrQ.size() != 0 || fenceQ.size() != 0) && n < maxCycles)
        begin
            tick();
            n++;
        end
        if (wrQ.size() != 0 || fenceQ.size() != 0)
        begin
            timeouts++;
            $display("Timeout: responses still missing after %s", what);
        end
    endtask

    task automatic waitAlmFull(input logic level, input int maxCycles, input string what);
        int n;
        n = 0;
        while (reqAlmFull !== level && n < maxCycles)
        begin
            tick();
            n++;
        end
        if (reqAlmFull !== level)
        begin
            timeouts++;
            $display("Timeout: %s", what);
        end
    endtask

    initial
    begin
        logic [15:0] r;
        lfsrState     = 16'd37;
        valueErrs     = 0;
        flagErrs      = 0;
        protoErrs     = 0;
        timeouts      = 0;
        wrIssued      = 0;
        cycleCnt      = 0;
        slotBusy      = '0;
        arstN         = 1'b0;
        reqWrValid    = 1'b0;
        reqFenceValid = 1'b0;
        reqHdr        = '0;
        memAlmFull    = 1'b0;
        completeEn    = 1'b0;
        pick          = '0;
        repeat (10) @(posedge clk);
        #5;
        arstN = 1'b1;
        @(negedge clk);
        compareFlag("rspValid", rspValid, 1'b0);
        compareFlag("reqAlmFull", reqAlmFull, 1'b0);

        // Random writes and fences with random gaps, shuffled completions
        tick();
        completeEn = 1'b1;
        for (int k = 0; k < nRandReqs; k++)
        begin
            tick();
            waitAlmFull(1'b0, 200, "almost-full stayed high in random traffic");
            randBits(3, r);
            if (r[2:0] == 3'd0)
            begin
                sendFence();
            end
            else
            begin
                sendWrite();
            end
            randBits(2, r);
            repeat (int'(r[1:0])) tick();
        end
        waitDrain(400, "random traffic");

        // The fence response meets a done head slot, which must wait a cycle
        for (int k = 0; k < 3; k++)
        begin
            tick();
            sendWrite();
            tick();
            tick();
            sendFence();
            waitDrain(50, "fence bypass");
        end

        // Fill to the reserve with memory silent
        tick();
        completeEn = 1'b0;
        for (int k = 0; k < nEntries - minFreeSlots; k++)
        begin
            tick();
            sendWrite();
            @(negedge clk);
            compareFlag("reqAlmFull", reqAlmFull, 1'b0);
        end
        tick();
        @(negedge clk);
        compareFlag("reqAlmFull", reqAlmFull, 1'b1);
        tick();
        completeEn = 1'b1;
        waitAlmFull(1'b0, 100, "almost-full did not fall after completions");
        waitDrain(100, "filling the scoreboard");

        // Memory back-pressure reaches the user at once, in-flight writes finish
        tick();
        memAlmFull = 1'b1;
        @(negedge clk);
        compareFlag("reqAlmFull", reqAlmFull, 1'b1);
        for (int k = 0; k < minFreeSlots; k++)
        begin
            tick();
            sendWrite();
        end
        tick();
        memAlmFull = 1'b0;
        @(negedge clk);
        compareFlag("reqAlmFull", reqAlmFull, 1'b0);
        waitDrain(100, "memory back-pressure");

        $display("Errors: value %0d, flag %0d, protocol %0d, timeout %0d",
                 valueErrs, flagErrs, protoErrs, timeouts);
        if (valueErrs + flagErrs + protoErrs + timeouts == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
wrSortPkg.sv
wrScoreboard.sv
wrReqTagger.sv
wrRspSorter.sv
wrSortShim.sv
tbWrMemModel.sv
tbWrSort.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the write-response sorting shim testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tbWrSort -Mdir obj_dir -o simWrSort &&
    simOut="$(./obj_dir/simWrSort)" ||
    { echo "Build or simulation run failed"; exit 1; }

echo "$simOut"
echo "$simOut" | grep -qx "STATUS: PASS" && exit 0 || exit 1
